// File: dv/glb_chain_asserts.sv
`timescale 1ns/1ps
`include "glb_defs.svh"

module glb_chain_asserts (
    input logic clk,
    input logic reset,
    input logic proc_rd_en,
    input logic proc_rd_data_valid,
    input logic cfg_rd_en,
    input logic cfg_rd_data_valid
);

    // one start stage, one stage per tile, one return stage
    localparam int RD_LATENCY = `GLB_NUM_TILES + 2;

    proc_rd_latency: assert property (@(posedge clk) disable iff (reset)
        proc_rd_data_valid == $past(proc_rd_en, RD_LATENCY))
        else $error("processor read valid does not follow its request by %0d cycles",
                    RD_LATENCY);

    cfg_rd_latency: assert property (@(posedge clk) disable iff (reset)
        cfg_rd_data_valid == $past(cfg_rd_en, RD_LATENCY))
        else $error("config read valid does not follow its request by %0d cycles",
                    RD_LATENCY);

    no_valid_in_reset: assert property (@(posedge clk)
        reset |-> (!proc_rd_data_valid && !cfg_rd_data_valid))
        else $error("read valid high while reset is asserted");

endmodule

bind glb_chain_top glb_chain_asserts u_asserts (
    .clk                (clk),
    .reset              (reset),
    .proc_rd_en         (proc_rd_en),
    .proc_rd_data_valid (proc_rd_data_valid),
    .cfg_rd_en          (cfg_rd_en),
    .cfg_rd_data_valid  (cfg_rd_data_valid)
);

// File: dv/glb_chain_tb.sv
`timescale 1ns/1ps
`include "glb_defs.svh"

module glb_chain_tb;
    import glb_pkg::*;

    localparam int RD_LATENCY = `GLB_NUM_TILES + 2;
    localparam int NUM_WORDS  = 1 << `GLB_ADDR_WIDTH;
    localparam int PARTIAL_N  = 24;
    localparam int RAND_N     = 400;
    localparam int WP_N       = 8;
    // reset, then each phase with its drain, then the final drain
    localparam int STIM_CYCLES = 3 + 28 + (2 * NUM_WORDS + 10) + (2 * PARTIAL_N + 10)
                               + (RAND_N + 10) + (6 * WP_N + 16) + 40 + 20;
    localparam int unsigned CYCLE_LIMIT = 2 * STIM_CYCLES + 50;

    typedef struct packed {
        int unsigned                     due;
        logic [`GLB_ADDR_WIDTH-1:0]      addr;
        logic [`GLB_DATA_WIDTH-1:0]      data;
    } proc_exp_t;

    typedef struct packed {
        int unsigned                     due;
        logic [`GLB_CFG_ADDR_WIDTH-1:0]  addr;
        logic [`GLB_CFG_DATA_WIDTH-1:0]  data;
    } cfg_exp_t;

    logic                              clk;
    logic                              reset;
    logic                              proc_wr_en;
    logic [`GLB_STRB_WIDTH-1:0]        proc_wr_strb;
    logic [`GLB_ADDR_WIDTH-1:0]        proc_wr_addr;
    logic [`GLB_DATA_WIDTH-1:0]        proc_wr_data;
    logic                              proc_rd_en;
    logic [`GLB_ADDR_WIDTH-1:0]        proc_rd_addr;
    logic [`GLB_DATA_WIDTH-1:0]        proc_rd_data;
    logic                              proc_rd_data_valid;
    logic                              cfg_wr_en;
    logic                              cfg_rd_en;
    logic [`GLB_CFG_ADDR_WIDTH-1:0]    cfg_addr;
    logic [`GLB_CFG_DATA_WIDTH-1:0]    cfg_wr_data;
    logic [`GLB_CFG_DATA_WIDTH-1:0]    cfg_rd_data;
    logic                              cfg_rd_data_valid;

    // expected responses in issue order, consumed by index
    proc_exp_t   exp_proc_q[$];
    cfg_exp_t    exp_cfg_q[$];
    int unsigned proc_head = 0;
    int unsigned cfg_head = 0;
    int unsigned cycle_count = 0;

    logic [`GLB_DATA_WIDTH-1:0]     model_mem  [NUM_WORDS];
    logic [`GLB_CFG_DATA_WIDTH-1:0] model_ctrl [`GLB_NUM_TILES];
    logic [`GLB_CFG_DATA_WIDTH-1:0] model_tag  [`GLB_NUM_TILES];

    glb_chain_top UUT (
        .clk                (clk),
        .reset              (reset),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid),
        .cfg_wr_en          (cfg_wr_en),
        .cfg_rd_en          (cfg_rd_en),
        .cfg_addr           (cfg_addr),
        .cfg_wr_data        (cfg_wr_data),
        .cfg_rd_data        (cfg_rd_data),
        .cfg_rd_data_valid  (cfg_rd_data_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [`GLB_DATA_WIDTH-1:0] ref_read(
        input logic [`GLB_ADDR_WIDTH-1:0] addr
    );
        return model_mem[addr];
    endfunction

    function automatic logic [`GLB_CFG_DATA_WIDTH-1:0] ref_cfg_read(
        input logic [`GLB_CFG_ADDR_WIDTH-1:0] addr
    );
        logic [`GLB_TILE_BITS-1:0] tile;
        tile = addr[`GLB_CFG_ADDR_WIDTH-1 -: `GLB_TILE_BITS];
        case (addr[1:0])
            2'd0:    return model_ctrl[tile];
            2'd1:    return model_tag[tile];
            default: return '0;
        endcase
    endfunction

    function automatic void model_write(input wr_packet_t w);
        logic [`GLB_TILE_BITS-1:0] tile;
        tile = w.wr_addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_BITS];
        // protected tile drops the whole write
        if (model_ctrl[tile][0]) begin
            return;
        end
        for (int b = 0; b < `GLB_STRB_WIDTH; b++) begin
            if (w.wr_strb[b]) begin
                model_mem[w.wr_addr][b*8 +: 8] = w.wr_data[b*8 +: 8];
            end
        end
    endfunction

    function automatic void model_cfg_write(input cfg_bus_t c);
        logic [`GLB_TILE_BITS-1:0] tile;
        tile = c.addr[`GLB_CFG_ADDR_WIDTH-1 -: `GLB_TILE_BITS];
        case (c.addr[1:0])
            2'd0:    model_ctrl[tile] = c.wr_data;
            2'd1:    model_tag[tile] = c.wr_data;
            default: ;
        endcase
    endfunction

    function automatic logic [`GLB_CFG_ADDR_WIDTH-1:0] cfg_addr_of(input int tile, input int sel);
        return {tile[`GLB_TILE_BITS-1:0], sel[1:0]};
    endfunction

    function automatic logic [`GLB_DATA_WIDTH-1:0] fill_word(
        input logic [`GLB_ADDR_WIDTH-1:0] addr
    );
        return {4{addr}} ^ 32'h5a3c_96e1;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    // one stimulus cycle; expectations are taken before this cycle's writes
    task automatic drive_cycle(input wr_packet_t w, input rdrq_packet_t r, input cfg_bus_t c);
        proc_exp_t   pe;
        cfg_exp_t    ce;
        int unsigned due;
        @(posedge clk);
        // response due RD_LATENCY cycles after this drive cycle
        due = cycle_count + 1 + RD_LATENCY;
        if (r.rd_en) begin
            pe.due  = due;
            pe.addr = r.rd_addr;
            pe.data = ref_read(r.rd_addr);
            exp_proc_q.push_back(pe);
        end
        if (c.rd_en) begin
            ce.due  = due;
            ce.addr = c.addr;
            ce.data = ref_cfg_read(c.addr);
            exp_cfg_q.push_back(ce);
        end
        if (w.wr_en) begin
            model_write(w);
        end
        if (c.wr_en) begin
            model_cfg_write(c);
        end
        proc_wr_en   <= w.wr_en;
        proc_wr_strb <= w.wr_strb;
        proc_wr_addr <= w.wr_addr;
        proc_wr_data <= w.wr_data;
        proc_rd_en   <= r.rd_en;
        proc_rd_addr <= r.rd_addr;
        cfg_wr_en    <= c.wr_en;
        cfg_rd_en    <= c.rd_en;
        cfg_addr     <= c.addr;
        cfg_wr_data  <= c.wr_data;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            drive_cycle('0, '0, '0);
        end
    endtask

    task automatic proc_write(
        input logic [`GLB_ADDR_WIDTH-1:0] addr,
        input logic [`GLB_STRB_WIDTH-1:0] strb,
        input logic [`GLB_DATA_WIDTH-1:0] data
    );
        wr_packet_t w;
        w = '{wr_en: 1'b1, wr_strb: strb, wr_addr: addr, wr_data: data};
        drive_cycle(w, '0, '0);
    endtask

    task automatic proc_read(input logic [`GLB_ADDR_WIDTH-1:0] addr);
        rdrq_packet_t r;
        r = '{rd_en: 1'b1, rd_addr: addr};
        drive_cycle('0, r, '0);
    endtask

    task automatic cfg_write(
        input logic [`GLB_CFG_ADDR_WIDTH-1:0] addr,
        input logic [`GLB_CFG_DATA_WIDTH-1:0] data
    );
        cfg_bus_t c;
        c = '{wr_en: 1'b1, rd_en: 1'b0, addr: addr, wr_data: data};
        drive_cycle('0, '0, c);
    endtask

    task automatic cfg_read(input logic [`GLB_CFG_ADDR_WIDTH-1:0] addr);
        cfg_bus_t c;
        c = '{wr_en: 1'b0, rd_en: 1'b1, addr: addr, wr_data: '0};
        drive_cycle('0, '0, c);
    endtask

    task automatic check_proc_response();
        proc_exp_t pe;
        if (proc_head < exp_proc_q.size() && exp_proc_q[proc_head].due == cycle_count) begin
            pe = exp_proc_q[proc_head];
            proc_head++;
            assert (proc_rd_data_valid === 1'b1) else begin
                stop_on_error($sformatf("read of address 0x%02h got no response in cycle %0d",
                                        pe.addr, cycle_count));
            end
            assert (proc_rd_data === pe.data) else begin
                stop_on_error($sformatf("[FAIL] %0t: read 0x%02h returned 0x%08h, expected 0x%08h",
                                        $time, pe.addr, proc_rd_data, pe.data));
            end
        end else begin
            assert (proc_rd_data_valid === 1'b0) else begin
                stop_on_error($sformatf("read response with no read due in cycle %0d",
                                        cycle_count));
            end
        end
    endtask

    task automatic check_cfg_response();
        cfg_exp_t ce;
        if (cfg_head < exp_cfg_q.size() && exp_cfg_q[cfg_head].due == cycle_count) begin
            ce = exp_cfg_q[cfg_head];
            cfg_head++;
            assert (cfg_rd_data_valid === 1'b1) else begin
                stop_on_error($sformatf("config read of 0x%0h got no response in cycle %0d",
                                        ce.addr, cycle_count));
            end
            assert (cfg_rd_data === ce.data) else begin
                stop_on_error($sformatf("[FAIL] %0t: config 0x%0h returned 0x%08h, expected 0x%08h",
                                        $time, ce.addr, cfg_rd_data, ce.data));
            end
        end else begin
            assert (cfg_rd_data_valid === 1'b0) else begin
                stop_on_error($sformatf("config response with no read due in cycle %0d",
                                        cycle_count));
            end
        end
    endtask

    // compare on the falling edge, away from the driven edge
    always @(negedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            stop_on_error($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
        end
        if (reset) begin
            assert (proc_rd_data_valid === 1'b0 && cfg_rd_data_valid === 1'b0) else begin
                stop_on_error("read valid high while reset is asserted");
            end
        end else begin
            check_proc_response();
            check_cfg_response();
        end
    end

    task automatic check_reset_values();
        idle(10);
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            cfg_read(cfg_addr_of(t, 0));
            cfg_read(cfg_addr_of(t, 1));
        end
        idle(10);
    endtask

    task automatic fill_and_read_all();
        for (int a = 0; a < NUM_WORDS; a++) begin
            proc_write(a[`GLB_ADDR_WIDTH-1:0], '1, fill_word(a[`GLB_ADDR_WIDTH-1:0]));
        end
        for (int a = 0; a < NUM_WORDS; a++) begin
            proc_read(a[`GLB_ADDR_WIDTH-1:0]);
        end
        idle(10);
    endtask

    task automatic partial_strobe_merge();
        logic [31:0] rnd;
        for (int i = 0; i < PARTIAL_N; i++) begin
            rnd = $urandom;
            proc_write(rnd[15:8], rnd[3:0], $urandom);
            proc_read(rnd[15:8]);
        end
        idle(10);
    endtask

    task automatic random_traffic();
        logic [31:0]                rnd;
        logic [`GLB_ADDR_WIDTH-1:0] last_wr_addr;
        wr_packet_t                 w;
        rdrq_packet_t               r;
        last_wr_addr = '0;
        for (int i = 0; i < RAND_N; i++) begin
            rnd = $urandom;
            w.wr_en   = rnd[0];
            w.wr_strb = rnd[7:4];
            w.wr_addr = rnd[15:8];
            w.wr_data = $urandom;
            r.rd_en   = rnd[1];
            // half the reads chase the previous write
            r.rd_addr = rnd[2] ? last_wr_addr : rnd[23:16];
            // bank has one port so a same-tile pair keeps only the write
            if (w.wr_en && r.rd_en &&
                w.wr_addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_BITS] ==
                r.rd_addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_BITS]) begin
                r.rd_en = 1'b0;
            end
            if (w.wr_en) begin
                last_wr_addr = w.wr_addr;
            end
            drive_cycle(w, r, '0);
        end
        idle(10);
    endtask

    task automatic write_protect_check();
        cfg_write(cfg_addr_of(2, 0), 32'h1);
        for (int j = 0; j < WP_N; j++) begin
            proc_write({2'd2, j[`GLB_WORD_BITS-1:0]}, '1, $urandom);
            proc_write({2'd1, j[`GLB_WORD_BITS-1:0]}, '1, $urandom);
        end
        cfg_read(cfg_addr_of(2, 0));
        for (int j = 0; j < WP_N; j++) begin
            proc_read({2'd2, j[`GLB_WORD_BITS-1:0]});
            proc_read({2'd1, j[`GLB_WORD_BITS-1:0]});
        end
        // unprotect and write again
        cfg_write(cfg_addr_of(2, 0), 32'h0);
        for (int j = 0; j < WP_N; j++) begin
            proc_write({2'd2, j[`GLB_WORD_BITS-1:0]}, '1, $urandom);
        end
        for (int j = 0; j < WP_N; j++) begin
            proc_read({2'd2, j[`GLB_WORD_BITS-1:0]});
        end
        idle(10);
    endtask

    task automatic tag_register_check();
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            cfg_write(cfg_addr_of(t, 1), $urandom);
            cfg_write(cfg_addr_of(t, 2), $urandom);
            cfg_write(cfg_addr_of(t, 3), $urandom);
        end
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            cfg_read(cfg_addr_of(t, 1));
            cfg_read(cfg_addr_of(t, 2));
            cfg_read(cfg_addr_of(t, 3));
        end
        idle(10);
    endtask

    initial begin
        void'($urandom(34525));
        reset        <= 1'b1;
        proc_wr_en   <= 1'b0;
        proc_wr_strb <= '0;
        proc_wr_addr <= '0;
        proc_wr_data <= '0;
        proc_rd_en   <= 1'b0;
        proc_rd_addr <= '0;
        cfg_wr_en    <= 1'b0;
        cfg_rd_en    <= 1'b0;
        cfg_addr     <= '0;
        cfg_wr_data  <= '0;
        for (int t = 0; t < `GLB_NUM_TILES; t++) begin
            model_ctrl[t] = '0;
            model_tag[t]  = '0;
        end
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        check_reset_values();
        fill_and_read_all();
        partial_strobe_merge();
        random_traffic();
        write_protect_check();
        tag_register_check();
        idle(20);

        if (proc_head == exp_proc_q.size() && cfg_head == exp_cfg_q.size()) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_on_error("responses still outstanding at the end of the run");
        end
    end

endmodule

// File: glb_chain_top.f
+incdir+include
hw/glb_pkg.sv
hw/glb_dummy_start.sv
hw/glb_tile_ctrl.sv
hw/glb_bank.sv
hw/glb_packet_pipe.sv
hw/glb_tile.sv
hw/glb_chain_top.sv
dv/glb_chain_asserts.sv
dv/glb_chain_tb.sv

// File: hw/glb_bank.sv
`timescale 1ns/1ps
`include "glb_defs.svh"

module glb_bank (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic                          rd_en,
    input  logic [`GLB_STRB_WIDTH-1:0]    strb,
    input  logic [`GLB_WORD_BITS-1:0]     addr,
    input  logic [`GLB_DATA_WIDTH-1:0]    wr_data,
    input  logic                          reset,
    output glb_pkg::rdrs_packet_t         own_rdrs
);

    logic [`GLB_DATA_WIDTH-1:0] mem [`GLB_BANK_WORDS];
    logic [`GLB_DATA_WIDTH-1:0] rd_data_q;
    logic                       rd_valid_q;

    // byte lanes written under strobe
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < `GLB_STRB_WIDTH; b++) begin
                if (strb[b]) begin
                    mem[addr][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
        // read-first on a shared cycle
        if (rd_en) begin
            rd_data_q <= mem[addr];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_en;
        end
    end

    assign own_rdrs.rd_data_valid = rd_valid_q;
    assign own_rdrs.rd_data       = rd_data_q;

endmodule

// File: hw/glb_chain_top.sv
`timescale 1ns/1ps
`include "glb_defs.svh"

module glb_chain_top (
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              proc_wr_en,
    input  logic [`GLB_STRB_WIDTH-1:0]        proc_wr_strb,
    input  logic [`GLB_ADDR_WIDTH-1:0]        proc_wr_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]        proc_wr_data,
    input  logic                              proc_rd_en,
    input  logic [`GLB_ADDR_WIDTH-1:0]        proc_rd_addr,
    output logic [`GLB_DATA_WIDTH-1:0]        proc_rd_data,
    output logic                              proc_rd_data_valid,

    input  logic                              cfg_wr_en,
    input  logic                              cfg_rd_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0]    cfg_addr,
    input  logic [`GLB_CFG_DATA_WIDTH-1:0]    cfg_wr_data,
    output logic [`GLB_CFG_DATA_WIDTH-1:0]    cfg_rd_data,
    output logic                              cfg_rd_data_valid
);
    import glb_pkg::*;

    // entry i feeds tile i and the last entry is the east end
    proc_packet_t proc_chain   [0:`GLB_NUM_TILES];
    cfg_bus_t     cfg_chain    [0:`GLB_NUM_TILES];
    cfg_rd_t      cfg_rd_chain [0:`GLB_NUM_TILES];

    glb_dummy_start u_start (
        .clk                (clk),
        .reset              (reset),
        .proc_wr_en         (proc_wr_en),
        .proc_wr_strb       (proc_wr_strb),
        .proc_wr_addr       (proc_wr_addr),
        .proc_wr_data       (proc_wr_data),
        .proc_rd_en         (proc_rd_en),
        .proc_rd_addr       (proc_rd_addr),
        .proc_rd_data       (proc_rd_data),
        .proc_rd_data_valid (proc_rd_data_valid),
        .cfg_wr_en          (cfg_wr_en),
        .cfg_rd_en          (cfg_rd_en),
        .cfg_addr           (cfg_addr),
        .cfg_wr_data        (cfg_wr_data),
        .cfg_rd_data        (cfg_rd_data),
        .cfg_rd_data_valid  (cfg_rd_data_valid),
        .proc_packet_w2e    (proc_chain[0]),
        .cfg_w2e            (cfg_chain[0]),
        .cfg_rd_w2e         (cfg_rd_chain[0]),
        .rdrs_ret           (proc_chain[`GLB_NUM_TILES].rdrs),
        .cfg_rd_ret         (cfg_rd_chain[`GLB_NUM_TILES])
    );

    for (genvar i = 0; i < `GLB_NUM_TILES; i++) begin : g_tile
        glb_tile #(
            .TILE_ID (i)
        ) u_tile (
            .clk        (clk),
            .reset      (reset),
            .proc_in    (proc_chain[i]),
            .proc_out   (proc_chain[i+1]),
            .cfg_in     (cfg_chain[i]),
            .cfg_out    (cfg_chain[i+1]),
            .cfg_rd_in  (cfg_rd_chain[i]),
            .cfg_rd_out (cfg_rd_chain[i+1])
        );
    end

endmodule

// File: hw/glb_dummy_start.sv
`timescale 1ns/1ps
`include "glb_defs.svh"

module glb_dummy_start (
    input  logic                              clk,
    input  logic                              reset,

    // processor
    input  logic                              proc_wr_en,
    input  logic [`GLB_STRB_WIDTH-1:0]        proc_wr_strb,
    input  logic [`GLB_ADDR_WIDTH-1:0]        proc_wr_addr,
    input  logic [`GLB_DATA_WIDTH-1:0]        proc_wr_data,
    input  logic                              proc_rd_en,
    input  logic [`GLB_ADDR_WIDTH-1:0]        proc_rd_addr,
    output logic [`GLB_DATA_WIDTH-1:0]        proc_rd_data,
    output logic                              proc_rd_data_valid,

    // configuration controller
    input  logic                              cfg_wr_en,
    input  logic                              cfg_rd_en,
    input  logic [`GLB_CFG_ADDR_WIDTH-1:0]    cfg_addr,
    input  logic [`GLB_CFG_DATA_WIDTH-1:0]    cfg_wr_data,
    output logic [`GLB_CFG_DATA_WIDTH-1:0]    cfg_rd_data,
    output logic                              cfg_rd_data_valid,

    // towards tile 0
    output glb_pkg::proc_packet_t             proc_packet_w2e,
    output glb_pkg::cfg_bus_t                 cfg_w2e,
    output glb_pkg::cfg_rd_t                  cfg_rd_w2e,

    // looped back from the east end
    input  glb_pkg::rdrs_packet_t             rdrs_ret,
    input  glb_pkg::cfg_rd_t                  cfg_rd_ret
);
    import glb_pkg::*;

    wr_packet_t   wr_q;
    rdrq_packet_t rdrq_q;
    cfg_bus_t     cfg_q;
    rdrs_packet_t rdrs_ret_q;
    cfg_rd_t      cfg_rd_ret_q;

    // one register stage each way
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_q         <= '0;
            rdrq_q       <= '0;
            cfg_q        <= '0;
            rdrs_ret_q   <= '0;
            cfg_rd_ret_q <= '0;
        end else begin
            wr_q.wr_en     <= proc_wr_en;
            wr_q.wr_strb   <= proc_wr_strb;
            wr_q.wr_addr   <= proc_wr_addr;
            wr_q.wr_data   <= proc_wr_data;
            rdrq_q.rd_en   <= proc_rd_en;
            rdrq_q.rd_addr <= proc_rd_addr;
            cfg_q.wr_en    <= cfg_wr_en;
            cfg_q.rd_en    <= cfg_rd_en;
            cfg_q.addr     <= cfg_addr;
            cfg_q.wr_data  <= cfg_wr_data;
            rdrs_ret_q     <= rdrs_ret;
            cfg_rd_ret_q   <= cfg_rd_ret;
        end
    end

    // no response originates at the west end
    assign proc_packet_w2e = '{wr: wr_q, rdrq: rdrq_q, rdrs: '0};
    assign cfg_w2e         = cfg_q;
    assign cfg_rd_w2e      = '0;

    assign proc_rd_data       = rdrs_ret_q.rd_data;
    assign proc_rd_data_valid = rdrs_ret_q.rd_data_valid;
    assign cfg_rd_data        = cfg_rd_ret_q.rd_data;
    assign cfg_rd_data_valid  = cfg_rd_ret_q.rd_data_valid;

endmodule

// File: hw/glb_packet_pipe.sv
`timescale 1ns/1ps
`include "glb_defs.svh"

module glb_packet_pipe (
    input  logic                      clk,
    input  logic                      reset,
    input  glb_pkg::proc_packet_t     proc_in,
    input  glb_pkg::cfg_bus_t         cfg_in,
    input  glb_pkg::cfg_rd_t          cfg_rd_in,
    input  glb_pkg::rdrs_packet_t     own_rdrs,
    input  glb_pkg::cfg_rd_t          own_cfg_rd,
    output glb_pkg::proc_packet_t     proc_out,
    output glb_pkg::cfg_bus_t         cfg_out,
    output glb_pkg::cfg_rd_t          cfg_rd_out
);
    import glb_pkg::*;

    proc_packet_t proc_q;
    cfg_bus_t     cfg_q;
    cfg_rd_t      cfg_rd_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            proc_q   <= '0;
            cfg_q    <= '0;
            cfg_rd_q <= '0;
        end else begin
            proc_q   <= proc_in;
            cfg_q    <= cfg_in;
            cfg_rd_q <= cfg_rd_in;
        end
    end

    // equal latency per read means own and passing responses never share a slot
    assign proc_out = '{
        wr:   proc_q.wr,
        rdrq: proc_q.rdrq,
        rdrs: own_rdrs.rd_data_valid ? own_rdrs : proc_q.rdrs
    };

    assign cfg_out    = cfg_q;
    assign cfg_rd_out = own_cfg_rd.rd_data_valid ? own_cfg_rd : cfg_rd_q;

endmodule

// File: hw/glb_pkg.sv
`include "glb_defs.svh"

package glb_pkg;

    typedef struct packed {
        logic                         wr_en;
        logic [`GLB_STRB_WIDTH-1:0]   wr_strb;
        logic [`GLB_ADDR_WIDTH-1:0]   wr_addr;
        logic [`GLB_DATA_WIDTH-1:0]   wr_data;
    } wr_packet_t;

    typedef struct packed {
        logic                         rd_en;
        logic [`GLB_ADDR_WIDTH-1:0]   rd_addr;
    } rdrq_packet_t;

    typedef struct packed {
        logic                         rd_data_valid;
        logic [`GLB_DATA_WIDTH-1:0]   rd_data;
    } rdrs_packet_t;

    typedef struct packed {
        wr_packet_t                   wr;
        rdrq_packet_t                 rdrq;
        rdrs_packet_t                 rdrs;
    } proc_packet_t;

    // one address shared by config writes and reads
    typedef struct packed {
        logic                             wr_en;
        logic                             rd_en;
        logic [`GLB_CFG_ADDR_WIDTH-1:0]   addr;
        logic [`GLB_CFG_DATA_WIDTH-1:0]   wr_data;
    } cfg_bus_t;

    typedef struct packed {
        logic                             rd_data_valid;
        logic [`GLB_CFG_DATA_WIDTH-1:0]   rd_data;
    } cfg_rd_t;

    // selects 2 and 3 are unmapped
    typedef enum logic [`GLB_CFG_ADDR_WIDTH-`GLB_TILE_BITS-1:0] {
        REG_CTRL = 0,
        REG_TAG  = 1
    } cfg_reg_e;

endpackage

// File: hw/glb_tile.sv
`timescale 1ns/1ps
`include "glb_defs.svh"

module glb_tile #(
    parameter int TILE_ID = 0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  glb_pkg::proc_packet_t     proc_in,
    output glb_pkg::proc_packet_t     proc_out,
    input  glb_pkg::cfg_bus_t         cfg_in,
    output glb_pkg::cfg_bus_t         cfg_out,
    input  glb_pkg::cfg_rd_t          cfg_rd_in,
    output glb_pkg::cfg_rd_t          cfg_rd_out
);
    import glb_pkg::*;

    logic                         bank_wr_en;
    logic                         bank_rd_en;
    logic [`GLB_STRB_WIDTH-1:0]   bank_strb;
    logic [`GLB_WORD_BITS-1:0]    bank_addr;
    rdrs_packet_t                 own_rdrs;
    cfg_rd_t                      own_cfg_rd;

    glb_tile_ctrl #(
        .TILE_ID (TILE_ID)
    ) u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .proc_in    (proc_in),
        .cfg_in     (cfg_in),
        .bank_wr_en (bank_wr_en),
        .bank_rd_en (bank_rd_en),
        .bank_strb  (bank_strb),
        .bank_addr  (bank_addr),
        .own_cfg_rd (own_cfg_rd)
    );

    glb_bank u_bank (
        .clk      (clk),
        .wr_en    (bank_wr_en),
        .rd_en    (bank_rd_en),
        .strb     (bank_strb),
        .addr     (bank_addr),
        .wr_data  (proc_in.wr.wr_data),
        .reset    (reset),
        .own_rdrs (own_rdrs)
    );

    glb_packet_pipe u_pipe (
        .clk        (clk),
        .reset      (reset),
        .proc_in    (proc_in),
        .cfg_in     (cfg_in),
        .cfg_rd_in  (cfg_rd_in),
        .own_rdrs   (own_rdrs),
        .own_cfg_rd (own_cfg_rd),
        .proc_out   (proc_out),
        .cfg_out    (cfg_out),
        .cfg_rd_out (cfg_rd_out)
    );

endmodule

// File: hw/glb_tile_ctrl.sv
`timescale 1ns/1ps
`include "glb_defs.svh"

module glb_tile_ctrl #(
    parameter int TILE_ID = 0
) (
    input  logic                          clk,
    input  logic                          reset,
    input  glb_pkg::proc_packet_t         proc_in,
    input  glb_pkg::cfg_bus_t             cfg_in,
    output logic                          bank_wr_en,
    output logic                          bank_rd_en,
    output logic [`GLB_STRB_WIDTH-1:0]    bank_strb,
    output logic [`GLB_WORD_BITS-1:0]     bank_addr,
    output glb_pkg::cfg_rd_t              own_cfg_rd
);
    import glb_pkg::*;

    localparam int REG_BITS = `GLB_CFG_ADDR_WIDTH - `GLB_TILE_BITS;
    localparam logic [`GLB_TILE_BITS-1:0] TILE_SEL = TILE_ID[`GLB_TILE_BITS-1:0];

    logic                           wr_hit;
    logic                           rd_hit;
    logic                           cfg_hit;
    cfg_reg_e                       cfg_sel;
    logic [`GLB_CFG_DATA_WIDTH-1:0] ctrl_reg;
    logic [`GLB_CFG_DATA_WIDTH-1:0] tag_reg;
    logic [`GLB_CFG_DATA_WIDTH-1:0] cfg_rd_mux;

    // ownership from the top address bits
    assign wr_hit  = proc_in.wr.wr_en &&
                     (proc_in.wr.wr_addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_BITS] == TILE_SEL);
    assign rd_hit  = proc_in.rdrq.rd_en &&
                     (proc_in.rdrq.rd_addr[`GLB_ADDR_WIDTH-1 -: `GLB_TILE_BITS] == TILE_SEL);
    assign cfg_hit = cfg_in.addr[`GLB_CFG_ADDR_WIDTH-1 -: `GLB_TILE_BITS] == TILE_SEL;
    assign cfg_sel = cfg_reg_e'(cfg_in.addr[REG_BITS-1:0]);

    // ctrl bit 0 is write protect
    assign bank_wr_en = wr_hit && !ctrl_reg[0];
    assign bank_rd_en = rd_hit;
    assign bank_strb  = proc_in.wr.wr_strb;
    // single port, so a same-tile read in a write cycle uses the write address
    assign bank_addr  = bank_wr_en ? proc_in.wr.wr_addr[`GLB_WORD_BITS-1:0]
                                   : proc_in.rdrq.rd_addr[`GLB_WORD_BITS-1:0];

    always_comb begin
        case (cfg_sel)
            REG_CTRL: cfg_rd_mux = ctrl_reg;
            REG_TAG:  cfg_rd_mux = tag_reg;
            default:  cfg_rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl_reg   <= '0;
            tag_reg    <= '0;
            own_cfg_rd <= '0;
        end else begin
            if (cfg_in.wr_en && cfg_hit) begin
                case (cfg_sel)
                    REG_CTRL: ctrl_reg <= cfg_in.wr_data;
                    REG_TAG:  tag_reg  <= cfg_in.wr_data;
                    default:  ;
                endcase
            end
            // answer lands in the pipe output slot
            own_cfg_rd.rd_data_valid <= cfg_in.rd_en && cfg_hit;
            own_cfg_rd.rd_data       <= cfg_rd_mux;
        end
    end

endmodule

// File: include/glb_defs.svh
`ifndef GLB_DEFS_SVH
`define GLB_DEFS_SVH

// chain size
`define GLB_NUM_TILES       4
`define GLB_TILE_BITS       2

// bank geometry
`define GLB_BANK_WORDS      64
`define GLB_WORD_BITS       6

// processor word address with the tile index in the top bits
`define GLB_ADDR_WIDTH      (`GLB_TILE_BITS + `GLB_WORD_BITS)
`define GLB_DATA_WIDTH      32
`define GLB_STRB_WIDTH      (`GLB_DATA_WIDTH / 8)

// config address is tile index over register select
`define GLB_CFG_ADDR_WIDTH  4
`define GLB_CFG_DATA_WIDTH  32

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build the chain testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module glb_chain_tb \
    -f glb_chain_top.f -o glb_chain_sim > build.log 2>&1 ||
    { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/glb_chain_sim > sim.log 2>&1
cat sim.log

grep -q "SIMULATION FAILED" sim.log && { echo "testbench reported failure"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "run ended without a result"; exit 1; }
exit 0
